// File: common/opq_config.svh
// Sizes of the operand queue. The widening logic assumes a 64-bit data word
// and the credit count assumes the operand buffer depth equals the credits

`ifndef OPQ_CONFIG_SVH
`define OPQ_CONFIG_SVH

// Operand word width in bits
`define OPQ_DATA_W 64

// Command buffer entries
`define OPQ_CMD_DEPTH 2

// Operand buffer entries, also the number of credits
`define OPQ_BUF_DEPTH 2

// Width of the destination element count
`define OPQ_CNT_W 16

`endif

// File: common/opq_pkg.sv
// Types shared by the operand queue blocks
// The command struct is 21 bits with a 16-bit element count

`include "opq_config.svh"

package opq_pkg;

  // Source element width
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  // Integer widening opcodes
  typedef enum logic [2:0] {
    CONV_NONE  = 3'd0,
    CONV_SEXT2 = 3'd1,
    CONV_ZEXT2 = 3'd2,
    CONV_SEXT4 = 3'd3,
    CONV_ZEXT4 = 3'd4
  } conv_e;

  // One command buffer entry
  typedef struct packed {
    eew_e                  eew;
    conv_e                 conv;
    logic [`OPQ_CNT_W-1:0] elem_count; // Destination elements to produce
  } opq_cmd_t;

endpackage

// File: hdl/opq_fifo.sv
// Synchronous FIFO without fall-through. A pushed entry shows at the head one
// cycle later. Flush empties it at the next edge and wins over push and pop

`timescale 1ns/1ps

module opq_fifo #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PtrW-1:0]  rptr_q, wptr_q;
  logic [CntW-1:0]  usage_q;

  assign data_o  = mem[rptr_q];
  assign empty_o = (usage_q == '0);
  assign full_o  = (usage_q == CntW'(DEPTH));

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rptr_q  <= '0;
      wptr_q  <= '0;
      usage_q <= '0;
    end else if (flush_i) begin
      rptr_q  <= '0;
      wptr_q  <= '0;
      usage_q <= '0;
    end else begin
      if (push_i) begin
        wptr_q <= (wptr_q == PtrW'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop_i) begin
        rptr_q <= (rptr_q == PtrW'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      usage_q <= usage_q + CntW'(push_i) - CntW'(pop_i);
    end
  end

  // A push into a full buffer is only safe when the head leaves in the same cycle
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i && full_o |-> pop_i);
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

// File: operand_queue/opq_widen.sv
// Integer widening of the head operand, elements stored contiguously
// Unsupported eew and opcode pairs pass the word through unchanged

`timescale 1ns/1ps
`include "opq_config.svh"

module opq_widen (
  input  logic [`OPQ_DATA_W-1:0] operand_i,
  input  opq_pkg::eew_e          eew_i,
  input  opq_pkg::conv_e         conv_i,
  input  logic [2:0]             select_i,
  output logic [`OPQ_DATA_W-1:0] operand_o
);

  logic       is_sext;
  logic [5:0] base;

  assign is_sext = (conv_i == opq_pkg::CONV_SEXT2) || (conv_i == opq_pkg::CONV_SEXT4);
  // Bit offset of the first source element in the head word
  assign base    = {select_i, 3'b000};

  always_comb begin
    operand_o = operand_i;
    unique case (conv_i)
      opq_pkg::CONV_SEXT2, opq_pkg::CONV_ZEXT2: begin
        unique case (eew_i)
          opq_pkg::EW8: begin
            for (int i = 0; i < 4; i++) begin
              operand_o[16*i +: 16] =
                {{8{is_sext & operand_i[base + 8*i + 7]}}, operand_i[base + 8*i +: 8]};
            end
          end
          opq_pkg::EW16: begin
            for (int i = 0; i < 2; i++) begin
              operand_o[32*i +: 32] =
                {{16{is_sext & operand_i[base + 16*i + 15]}}, operand_i[base + 16*i +: 16]};
            end
          end
          opq_pkg::EW32: begin
            operand_o = {{32{is_sext & operand_i[base + 31]}}, operand_i[base +: 32]};
          end
          default: ;
        endcase
      end
      opq_pkg::CONV_SEXT4, opq_pkg::CONV_ZEXT4: begin
        unique case (eew_i)
          opq_pkg::EW8: begin
            for (int i = 0; i < 2; i++) begin
              operand_o[32*i +: 32] =
                {{24{is_sext & operand_i[base + 8*i + 7]}}, operand_i[base + 8*i +: 8]};
            end
          end
          opq_pkg::EW16: begin
            operand_o = {{48{is_sext & operand_i[base + 15]}}, operand_i[base +: 16]};
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

// File: operand_queue/opq_input_buffer.sv
// Operand buffer with credit flow control. The register file issues only
// while operand_ready_o is high, so the buffer never overflows

`timescale 1ns/1ps
`include "opq_config.svh"

module opq_input_buffer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic [`OPQ_DATA_W-1:0] operand_i,
  input  logic                   operand_valid_i,
  input  logic                   operand_issued_i,
  input  logic                   pop_i,
  output logic [`OPQ_DATA_W-1:0] head_o,
  output logic                   head_valid_o,
  output logic                   operand_ready_o
);

  typedef logic [$clog2(`OPQ_BUF_DEPTH + 1)-1:0] credit_t;

  logic    empty;
  credit_t credits_d, credits_q;

  opq_fifo #(
    .WIDTH(`OPQ_DATA_W),
    .DEPTH(`OPQ_BUF_DEPTH)
  ) i_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .flush_i(flush_i),
    .push_i (operand_valid_i),
    .data_i (operand_i),
    .pop_i  (pop_i),
    .data_o (head_o),
    .empty_o(empty),
    .full_o ()
  );

  assign head_valid_o = ~empty;

  // Taken on issue, given back on pop, so a credit returns the cycle after a pop
  always_comb begin
    credits_d = credits_q;
    if (operand_issued_i && !pop_i) begin
      credits_d = credits_q + credit_t'(1);
    end else if (!operand_issued_i && pop_i) begin
      credits_d = credits_q - credit_t'(1);
    end
    if (flush_i) begin
      credits_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits_q <= '0;
    end else begin
      credits_q <= credits_d;
    end
  end

  assign operand_ready_o = (credits_q != credit_t'(`OPQ_BUF_DEPTH));

  // Every arriving word belongs to an earlier issue that still holds its credit
  a_push_has_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_valid_i |-> credits_q != '0);

endmodule

// File: operand_queue/opq_sequencer.sv
// Output sequencing of the operand queue. Select and count advance only on
// an accepted output; the head command and operand are assumed consistent

`timescale 1ns/1ps
`include "opq_config.svh"

module opq_sequencer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  opq_pkg::opq_cmd_t cmd_i,
  input  logic              cmd_valid_i,
  input  logic              head_valid_i,
  input  logic              operand_ready_i,
  output logic              operand_valid_o,
  output logic [2:0]        select_o,
  output logic              ibuf_pop_o,
  output logic              cmd_pop_o
);

  logic [2:0]            select_d, select_q;
  logic [`OPQ_CNT_W-1:0] count_d, count_q;
  logic [`OPQ_CNT_W:0]   count_next;
  logic [1:0]            shift;
  logic [2:0]            step;
  logic [3:0]            rpw;
  logic                  fire;

  // Log2 of the widening factor and the byte step, pass-through for the rest
  always_comb begin
    shift = 2'd0;
    step  = 3'd0;
    unique case (cmd_i.conv)
      opq_pkg::CONV_SEXT2, opq_pkg::CONV_ZEXT2: begin
        if (cmd_i.eew != opq_pkg::EW64) begin
          shift = 2'd1;
          step  = 3'd4;
        end
      end
      opq_pkg::CONV_SEXT4, opq_pkg::CONV_ZEXT4: begin
        if (cmd_i.eew inside {opq_pkg::EW8, opq_pkg::EW16}) begin
          shift = 2'd2;
          step  = 3'd2;
        end
      end
      default: ;
    endcase
  end

  // Results per output word
  assign rpw        = (4'd8 >> cmd_i.eew) >> shift;
  assign count_next = {1'b0, count_q} + {{(`OPQ_CNT_W - 3){1'b0}}, rpw};

  assign operand_valid_o = head_valid_i & cmd_valid_i;
  assign fire            = operand_valid_o & operand_ready_i;
  assign select_o        = select_q;

  always_comb begin
    select_d   = select_q;
    count_d    = count_q;
    ibuf_pop_o = 1'b0;
    cmd_pop_o  = 1'b0;
    if (fire) begin
      select_d = select_q + step;
      count_d  = count_next[`OPQ_CNT_W-1:0];
      // A zero step wraps at once, so pass-through pops every word
      if (select_d == '0) begin
        ibuf_pop_o = 1'b1;
      end
      if (count_next >= {1'b0, cmd_i.elem_count}) begin
        ibuf_pop_o = 1'b1;
        cmd_pop_o  = 1'b1;
        select_d   = '0;
        count_d    = '0;
      end
    end
    if (flush_i) begin
      select_d = '0;
      count_d  = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      select_q <= '0;
      count_q  <= '0;
    end else begin
      select_q <= select_d;
      count_q  <= count_d;
    end
  end

  // A command with no elements would never produce an output to end it
  a_cmd_count_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_i |-> cmd_i.elem_count != '0);

endmodule

// File: operand_queue/operand_queue.sv
// Operand queue for one vector lane. Commands and operands arrive as strobes
// with no back-pressure, and the register file is throttled by credits

`timescale 1ns/1ps
`include "opq_config.svh"

module operand_queue (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  // Command stream
  input  opq_pkg::opq_cmd_t      cmd_i,
  input  logic                   cmd_valid_i,
  // Register file side
  input  logic [`OPQ_DATA_W-1:0] operand_i,
  input  logic                   operand_valid_i,
  input  logic                   operand_issued_i,
  output logic                   operand_ready_o,
  // Functional unit side
  output logic [`OPQ_DATA_W-1:0] operand_o,
  output logic                   operand_valid_o,
  input  logic                   operand_ready_i
);

  opq_pkg::opq_cmd_t      cmd;
  logic                   cmd_empty;
  logic                   cmd_valid;
  logic                   cmd_pop;
  logic [`OPQ_DATA_W-1:0] ibuf_head;
  logic                   ibuf_head_valid;
  logic                   ibuf_pop;
  logic [2:0]             select;

  //////////////////////////////////////////////////
  // Command buffer
  //////////////////////////////////////////////////

  opq_fifo #(
    .WIDTH($bits(opq_pkg::opq_cmd_t)),
    .DEPTH(`OPQ_CMD_DEPTH)
  ) i_cmd_buffer (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .flush_i(flush_i),
    .push_i (cmd_valid_i),
    .data_i (cmd_i),
    .pop_i  (cmd_pop),
    .data_o (cmd),
    .empty_o(cmd_empty),
    .full_o ()
  );

  assign cmd_valid = ~cmd_empty;

  //////////////////////////////////////////////////
  // Operand path
  //////////////////////////////////////////////////

  opq_input_buffer i_input_buffer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_issued_i(operand_issued_i),
    .pop_i           (ibuf_pop),
    .head_o          (ibuf_head),
    .head_valid_o    (ibuf_head_valid),
    .operand_ready_o (operand_ready_o)
  );

  opq_widen i_widen (
    .operand_i(ibuf_head),
    .eew_i    (cmd.eew),
    .conv_i   (cmd.conv),
    .select_i (select),
    .operand_o(operand_o)
  );

  opq_sequencer i_sequencer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .cmd_i          (cmd),
    .cmd_valid_i    (cmd_valid),
    .head_valid_i   (ibuf_head_valid),
    .operand_ready_i(operand_ready_i),
    .operand_valid_o(operand_valid_o),
    .select_o       (select),
    .ibuf_pop_o     (ibuf_pop),
    .cmd_pop_o      (cmd_pop)
  );

endmodule

// File: dv/opq_checker.sv
// Reference model of the operand queue. Mirrors the input strobes at the
// rising edge and checks valid, ready, held data and every accepted output

`timescale 1ns/1ps
`include "opq_config.svh"

module opq_checker (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  opq_pkg::opq_cmd_t      cmd_i,
  input  logic                   cmd_valid_i,
  input  logic [`OPQ_DATA_W-1:0] operand_i,
  input  logic                   operand_valid_i,
  input  logic                   operand_issued_i,
  input  logic                   in_ready_i,
  input  logic [`OPQ_DATA_W-1:0] out_data_i,
  input  logic                   out_valid_i,
  input  logic                   out_ready_i,
  output int                     errors_o,
  output int                     checked_o,
  output int                     cmd_level_o,
  output int                     word_level_o
);

  logic [`OPQ_DATA_W-1:0] words_q [$];
  opq_pkg::opq_cmd_t      cmds_q [$];
  opq_pkg::opq_cmd_t      head;
  int                     sub_idx;
  int                     count;
  int                     credits;
  logic                   exp_valid;
  logic                   exp_ready;
  logic                   pop_word;
  logic                   stall_q;
  logic [`OPQ_DATA_W-1:0] held_q;
  logic [`OPQ_DATA_W-1:0] expected;

  function automatic int widening_factor(input opq_pkg::conv_e conv);
    case (conv)
      opq_pkg::CONV_SEXT2, opq_pkg::CONV_ZEXT2: return 2;
      opq_pkg::CONV_SEXT4, opq_pkg::CONV_ZEXT4: return 4;
      default: return 1;
    endcase
  endfunction

  function automatic int results_per_word(input opq_pkg::opq_cmd_t c);
    return 64 / (8 << c.eew) / widening_factor(c.conv);
  endfunction

  // Output word k of the current input word, elements stored contiguously
  function automatic logic [63:0] widen_model(input logic [63:0] word,
                                             input opq_pkg::opq_cmd_t c,
                                             input int k);
    int          sw;
    int          dw;
    int          f;
    int          rpw;
    int          idx;
    logic        sext;
    logic [63:0] mask;
    logic [63:0] dmask;
    logic [63:0] elem;
    logic [63:0] res;
    sw   = 8 << c.eew;
    f    = widening_factor(c.conv);
    dw   = sw * f;
    sext = (c.conv == opq_pkg::CONV_SEXT2) || (c.conv == opq_pkg::CONV_SEXT4);
    if (f == 1 || dw > 64) begin
      return word;
    end
    rpw   = 64 / dw;
    mask  = (64'h1 << sw) - 64'h1;
    dmask = (dw == 64) ? '1 : (64'h1 << dw) - 64'h1;
    res   = '0;
    for (int i = 0; i < rpw; i++) begin
      idx  = (k % f) * rpw + i;
      elem = (word >> (idx * sw)) & mask;
      if (sext && elem[sw-1]) begin
        elem = elem | ~mask;
      end
      res = res | ((elem & dmask) << (i * dw));
    end
    return res;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors_o++;
    $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      words_q.delete();
      cmds_q.delete();
      sub_idx      = 0;
      count        = 0;
      credits      = 0;
      stall_q      = 1'b0;
      cmd_level_o  = 0;
      word_level_o = 0;
    end else begin
      exp_valid = (words_q.size() != 0) && (cmds_q.size() != 0);
      exp_ready = (credits < `OPQ_BUF_DEPTH);
      if (out_valid_i !== exp_valid) begin
        report_mismatch("operand_valid_o", {63'b0, out_valid_i}, {63'b0, exp_valid});
      end
      if (in_ready_i !== exp_ready) begin
        report_mismatch("operand_ready_o", {63'b0, in_ready_i}, {63'b0, exp_ready});
      end
      // Output must hold while the consumer stalls
      if (stall_q && out_data_i !== held_q) begin
        report_mismatch("operand_o", out_data_i, held_q);
      end
      stall_q  = 1'b0;
      pop_word = 1'b0;
      if (flush_i) begin
        words_q.delete();
        cmds_q.delete();
        sub_idx = 0;
        count   = 0;
        credits = 0;
      end else begin
        if (exp_valid && out_ready_i) begin
          head     = cmds_q[0];
          expected = widen_model(words_q[0], head, sub_idx);
          checked_o++;
          if (out_data_i !== expected) begin
            report_mismatch("operand_o", out_data_i, expected);
          end
          count   = count + results_per_word(head);
          sub_idx = sub_idx + 1;
          if (count >= int'(head.elem_count)) begin
            pop_word = 1'b1;
            void'(cmds_q.pop_front());
            count   = 0;
            sub_idx = 0;
          end else if (sub_idx == widening_factor(head.conv)) begin
            pop_word = 1'b1;
            sub_idx  = 0;
          end
          if (pop_word) begin
            void'(words_q.pop_front());
          end
        end else if (exp_valid) begin
          stall_q = 1'b1;
          held_q  = out_data_i;
        end
        credits = credits + int'(operand_issued_i) - int'(pop_word);
        if (operand_valid_i) begin
          words_q.push_back(operand_i);
        end
        if (cmd_valid_i) begin
          cmds_q.push_back(cmd_i);
        end
      end
      cmd_level_o  = cmds_q.size();
      word_level_o = words_q.size();
    end
  end

endmodule

// File: dv/tb_operand_queue.sv
// Random commands and operands from a fixed seed, one flush mid-stream
// Operand data follows its issue strobe by exactly one cycle

`timescale 1ns/1ps
`include "opq_config.svh"

module tb_operand_queue;

  localparam int NumCmds  = 60;
  localparam int ClkPer   = 8;
  localparam int FlushCmd = NumCmds / 2;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   flush_i;
  opq_pkg::opq_cmd_t      cmd_i;
  logic                   cmd_valid_i;
  logic [`OPQ_DATA_W-1:0] operand_i;
  logic                   operand_valid_i;
  logic                   operand_issued_i;
  logic                   operand_ready_o;
  logic [`OPQ_DATA_W-1:0] operand_o;
  logic                   operand_valid_o;
  logic                   operand_ready_i;

  int                     errors;
  int                     checked;
  int                     cmd_level;
  int                     word_level;
  logic                   pend;
  logic [`OPQ_DATA_W-1:0] pend_word;
  int                     seed;

  operand_queue DUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .cmd_i           (cmd_i),
    .cmd_valid_i     (cmd_valid_i),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_issued_i(operand_issued_i),
    .operand_ready_o (operand_ready_o),
    .operand_o       (operand_o),
    .operand_valid_o (operand_valid_o),
    .operand_ready_i (operand_ready_i)
  );

  opq_checker i_checker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .cmd_i           (cmd_i),
    .cmd_valid_i     (cmd_valid_i),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_issued_i(operand_issued_i),
    .in_ready_i      (operand_ready_o),
    .out_data_i      (operand_o),
    .out_valid_i     (operand_valid_o),
    .out_ready_i     (operand_ready_i),
    .errors_o        (errors),
    .checked_o       (checked),
    .cmd_level_o     (cmd_level),
    .word_level_o    (word_level)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPer / 2) clk_i = ~clk_i;
  end

  function automatic int conv_factor(input opq_pkg::conv_e conv);
    case (conv)
      opq_pkg::CONV_SEXT2, opq_pkg::CONV_ZEXT2: return 2;
      opq_pkg::CONV_SEXT4, opq_pkg::CONV_ZEXT4: return 4;
      default: return 1;
    endcase
  endfunction

  // Input words a command consumes
  function automatic int input_words(input opq_pkg::opq_cmd_t c);
    int f;
    int rpw;
    int outs;
    f    = conv_factor(c.conv);
    rpw  = 64 / (8 << c.eew) / f;
    outs = (int'(c.elem_count) + rpw - 1) / rpw;
    return (outs + f - 1) / f;
  endfunction

  function automatic opq_pkg::opq_cmd_t random_cmd();
    opq_pkg::opq_cmd_t c;
    c.conv = opq_pkg::conv_e'($urandom_range(4, 0));
    case (c.conv)
      opq_pkg::CONV_NONE: c.eew = opq_pkg::eew_e'($urandom_range(3, 0));
      opq_pkg::CONV_SEXT2, opq_pkg::CONV_ZEXT2: c.eew = opq_pkg::eew_e'($urandom_range(2, 0));
      default: c.eew = opq_pkg::eew_e'($urandom_range(1, 0));
    endcase
    c.elem_count = `OPQ_CNT_W'($urandom_range(40, 1));
    return c;
  endfunction

  // Advance to the falling edge and drive the default values of a cycle
  task automatic next_cycle();
    @(negedge clk_i);
    flush_i          = 1'b0;
    cmd_valid_i      = 1'b0;
    operand_issued_i = 1'b0;
    operand_valid_i  = pend;
    operand_i        = pend_word;
    pend             = 1'b0;
    operand_ready_i  = ($urandom_range(3, 0) != 0);
  endtask

  task automatic push_cmd(input opq_pkg::opq_cmd_t c);
    forever begin
      next_cycle();
      if (cmd_level < `OPQ_CMD_DEPTH) begin
        cmd_i       = c;
        cmd_valid_i = 1'b1;
        break;
      end
    end
  endtask

  task automatic issue_word();
    forever begin
      next_cycle();
      if (operand_ready_o) begin
        operand_issued_i = 1'b1;
        pend             = 1'b1;
        pend_word        = {$urandom, $urandom};
        break;
      end
    end
  endtask

  task automatic flush_queue();
    next_cycle();
    flush_i = 1'b1;
    next_cycle();
  endtask

  initial begin
    opq_pkg::opq_cmd_t c;
    int                n;
    seed             = $urandom(32'hcbeb7a68);
    rst_ni           = 1'b0;
    flush_i          = 1'b0;
    cmd_i            = '0;
    cmd_valid_i      = 1'b0;
    operand_i        = '0;
    operand_valid_i  = 1'b0;
    operand_issued_i = 1'b0;
    operand_ready_i  = 1'b0;
    pend             = 1'b0;
    pend_word        = '0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int k = 0; k < NumCmds; k++) begin
      c = random_cmd();
      n = input_words(c);
      push_cmd(c);
      if (k == FlushCmd) begin
        for (int w = 0; w < (n + 1) / 2; w++) begin
          issue_word();
        end
        flush_queue();
      end else begin
        for (int w = 0; w < n; w++) begin
          issue_word();
        end
      end
    end

    // Drain
    next_cycle();
    while (cmd_level != 0 || word_level != 0) begin
      next_cycle();
    end
    repeat (4) next_cycle();

    if (checked == 0) begin
      $display("No output was accepted during the run");
    end
    $display("Errors: %0d, outputs checked: %0d", errors, checked);
    if (errors == 0 && checked != 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NumCmds * 200 * ClkPer);
    $display("Watchdog expired, the queue stopped producing outputs");
    $display("tests failed");
    $finish;
  end

endmodule

// File: opq.f
+incdir+common
common/opq_pkg.sv
hdl/opq_fifo.sv
operand_queue/opq_widen.sv
operand_queue/opq_input_buffer.sv
operand_queue/opq_sequencer.sv
operand_queue/operand_queue.sv
dv/opq_checker.sv
dv/tb_operand_queue.sv
